//--- hdl/udp_checksum_pkg.sv
// ********************
// UDP header widths, sizes and the engine state type
// FIFO depths must be powers of two
// ********************

package udp_checksum_pkg;

    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] udp_port_t;
    typedef logic [15:0] udp_len_t;
    typedef logic [15:0] csum_t;
    typedef logic [31:0] csum_acc_t;
    typedef logic [7:0]  byte_t;

    // IP protocol number for UDP, summed in the pseudo header
    localparam int UDP_PROTOCOL = 17;
    // UDP header size in bytes
    localparam int UDP_HDR_BYTES = 8;

    localparam int HDR_FIFO_DEPTH = 8;
    localparam int PAYLOAD_FIFO_DEPTH = 2048;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_SUM_SRC_IP,
        ST_SUM_DST_IP,
        ST_SUM_PORTS,
        ST_SUM_PAYLOAD,
        ST_FINISH
    } sum_state_t;

endpackage

//--- hdl/udp_hdr_if.sv
// ********************
// one header record per valid pulse; ready means room in the queue
// ********************

`timescale 1ns/1ps

interface udp_hdr_if;
    import udp_checksum_pkg::*;

    logic      valid;
    logic      ready;
    ip_addr_t  src_ip;
    ip_addr_t  dst_ip;
    udp_port_t src_port;
    udp_port_t dst_port;
    udp_len_t  length;
    csum_t     checksum;

    modport producer (
        output valid, src_ip, dst_ip, src_port, dst_port, length, checksum,
        input  ready
    );

    modport consumer (
        input  valid, src_ip, dst_ip, src_port, dst_port, length, checksum,
        output ready
    );

endinterface

//--- hdl/udp_byte_if.sv
// ********************
// payload bytes, transfer on valid and ready both high
// ********************

`timescale 1ns/1ps

interface udp_byte_if;
    import udp_checksum_pkg::*;

    byte_t data;
    logic  valid;
    logic  last;
    logic  ready;

    modport producer (
        output data, valid, last,
        input  ready
    );

    modport consumer (
        input  data, valid, last,
        output ready
    );

endinterface

//--- hdl/udp_sum_engine.sv
// ********************
// one frame at a time; zero checksum is not mapped to 16'hffff
// ********************

`timescale 1ns/1ps

module udp_sum_engine (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       s_hdr_valid,
    output logic                       s_hdr_ready,
    input  udp_checksum_pkg::ip_addr_t  s_ip_source_ip,
    input  udp_checksum_pkg::ip_addr_t  s_ip_dest_ip,
    input  udp_checksum_pkg::udp_port_t s_udp_source_port,
    input  udp_checksum_pkg::udp_port_t s_udp_dest_port,
    input  udp_checksum_pkg::byte_t     s_payload_tdata,
    input  logic                       s_payload_tvalid,
    input  logic                       s_payload_tlast,
    output logic                       s_payload_tready,
    udp_hdr_if.producer                hdr,
    udp_byte_if.producer               pay,
    output logic                       busy
);
    import udp_checksum_pkg::*;

    sum_state_t  state;
    sum_state_t  state_next;
    logic        hdr_ready_next;
    logic        hdr_valid_reg;
    logic        hdr_valid_next;
    logic        store_hdr;
    logic        in_payload;
    logic        byte_taken;

    ip_addr_t    src_ip_reg;
    ip_addr_t    dst_ip_reg;
    udp_port_t   src_port_reg;
    udp_port_t   dst_port_reg;
    udp_len_t    frame_len;
    udp_len_t    frame_len_next;
    csum_acc_t   acc;
    csum_acc_t   acc_next;
    logic [16:0] fold_part;
    csum_t       fold_sum;

    // payload only flows while summing it
    assign in_payload       = (state == ST_SUM_PAYLOAD);
    assign s_payload_tready = pay.ready && in_payload;
    assign byte_taken       = s_payload_tvalid && s_payload_tready;

    assign pay.data  = s_payload_tdata;
    assign pay.valid = s_payload_tvalid && in_payload;
    assign pay.last  = s_payload_tlast;

    // end-around carry, upper half folded into lower half
    assign fold_part = {1'b0, acc[15:0]} + {1'b0, acc[31:16]};
    assign fold_sum  = fold_part[15:0] + {15'd0, fold_part[16]};

    always_comb begin
        state_next     = state;
        hdr_ready_next = 1'b0;
        hdr_valid_next = 1'b0;
        store_hdr      = 1'b0;
        frame_len_next = frame_len;
        acc_next       = acc;

        case (state)
            ST_IDLE: begin
                hdr_ready_next = hdr.ready;
                if (s_hdr_valid && s_hdr_ready) begin
                    store_hdr      = 1'b1;
                    hdr_ready_next = 1'b0;
                    frame_len_next = udp_len_t'(UDP_HDR_BYTES);
                    // protocol plus both length fields, header part only
                    acc_next       = csum_acc_t'(UDP_PROTOCOL + 2 * UDP_HDR_BYTES);
                    state_next     = ST_SUM_SRC_IP;
                end
            end
            ST_SUM_SRC_IP: begin
                acc_next   = acc + {16'd0, src_ip_reg[31:16]} + {16'd0, src_ip_reg[15:0]};
                state_next = ST_SUM_DST_IP;
            end
            ST_SUM_DST_IP: begin
                acc_next   = acc + {16'd0, dst_ip_reg[31:16]} + {16'd0, dst_ip_reg[15:0]};
                state_next = ST_SUM_PORTS;
            end
            ST_SUM_PORTS: begin
                acc_next   = acc + {16'd0, src_port_reg} + {16'd0, dst_port_reg};
                state_next = ST_SUM_PAYLOAD;
            end
            ST_SUM_PAYLOAD: begin
                if (byte_taken) begin
                    // even offset is the high byte of a word
                    // the 2 counts this byte in both length fields
                    if (frame_len[0]) begin
                        acc_next = acc + {24'd0, s_payload_tdata} + 32'd2;
                    end else begin
                        acc_next = acc + {16'd0, s_payload_tdata, 8'd0} + 32'd2;
                    end
                    frame_len_next = frame_len + 16'd1;
                    if (s_payload_tlast) begin
                        state_next = ST_FINISH;
                    end
                end
            end
            ST_FINISH: begin
                acc_next       = {16'd0, ~fold_sum};
                hdr_valid_next = 1'b1;
                state_next     = ST_IDLE;
            end
            default: begin
                state_next = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state         <= ST_IDLE;
            s_hdr_ready   <= 1'b0;
            hdr_valid_reg <= 1'b0;
            busy          <= 1'b0;
        end else begin
            state         <= state_next;
            s_hdr_ready   <= hdr_ready_next;
            hdr_valid_reg <= hdr_valid_next;
            busy          <= (state_next != ST_IDLE);
        end

        frame_len <= frame_len_next;
        acc       <= acc_next;

        if (store_hdr) begin
            src_ip_reg   <= s_ip_source_ip;
            dst_ip_reg   <= s_ip_dest_ip;
            src_port_reg <= s_udp_source_port;
            dst_port_reg <= s_udp_dest_port;
        end
    end

    assign hdr.valid    = hdr_valid_reg;
    assign hdr.src_ip   = src_ip_reg;
    assign hdr.dst_ip   = dst_ip_reg;
    assign hdr.src_port = src_port_reg;
    assign hdr.dst_port = dst_port_reg;
    assign hdr.length   = frame_len;
    assign hdr.checksum = acc[15:0];

endmodule

//--- hdl/udp_header_fifo.sv
// ********************
// DEPTH must be a power of two; writes are not checked against full
// ********************

`timescale 1ns/1ps

module udp_header_fifo #(
    parameter int DEPTH = 8
) (
    input  logic                        clk,
    input  logic                        rst,
    udp_hdr_if.consumer                 hdr,
    output logic                        m_hdr_valid,
    input  logic                        m_hdr_ready,
    output udp_checksum_pkg::ip_addr_t  m_ip_source_ip,
    output udp_checksum_pkg::ip_addr_t  m_ip_dest_ip,
    output udp_checksum_pkg::udp_port_t m_udp_source_port,
    output udp_checksum_pkg::udp_port_t m_udp_dest_port,
    output udp_checksum_pkg::udp_len_t  m_udp_length,
    output udp_checksum_pkg::csum_t     m_udp_checksum
);
    import udp_checksum_pkg::*;

    localparam int ADDR_W = $clog2(DEPTH);

    ip_addr_t  src_ip_mem   [DEPTH];
    ip_addr_t  dst_ip_mem   [DEPTH];
    udp_port_t src_port_mem [DEPTH];
    udp_port_t dst_port_mem [DEPTH];
    udp_len_t  length_mem   [DEPTH];
    csum_t     checksum_mem [DEPTH];

    logic [ADDR_W:0] wr_ptr;
    logic [ADDR_W:0] rd_ptr;
    logic [ADDR_W:0] level;
    logic            full;
    logic            empty;
    logic            rd_en;

    // extra pointer bit tells a full store from an empty one
    assign full  = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]) &&
                   (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);
    assign empty = (wr_ptr == rd_ptr);
    assign level = wr_ptr - rd_ptr;

    // a record written this cycle already takes the last free slot
    assign hdr.ready = !full && !(hdr.valid && level == (ADDR_W + 1)'(DEPTH - 1));

    assign rd_en = !empty && (m_hdr_ready || !m_hdr_valid);

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            m_hdr_valid <= 1'b0;
        end else begin
            if (hdr.valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr      <= rd_ptr + 1'b1;
                m_hdr_valid <= 1'b1;
            end else if (m_hdr_ready) begin
                m_hdr_valid <= 1'b0;
            end
        end

        if (hdr.valid) begin
            src_ip_mem[wr_ptr[ADDR_W-1:0]]   <= hdr.src_ip;
            dst_ip_mem[wr_ptr[ADDR_W-1:0]]   <= hdr.dst_ip;
            src_port_mem[wr_ptr[ADDR_W-1:0]] <= hdr.src_port;
            dst_port_mem[wr_ptr[ADDR_W-1:0]] <= hdr.dst_port;
            length_mem[wr_ptr[ADDR_W-1:0]]   <= hdr.length;
            checksum_mem[wr_ptr[ADDR_W-1:0]] <= hdr.checksum;
        end

        // output stage
        if (rd_en) begin
            m_ip_source_ip    <= src_ip_mem[rd_ptr[ADDR_W-1:0]];
            m_ip_dest_ip      <= dst_ip_mem[rd_ptr[ADDR_W-1:0]];
            m_udp_source_port <= src_port_mem[rd_ptr[ADDR_W-1:0]];
            m_udp_dest_port   <= dst_port_mem[rd_ptr[ADDR_W-1:0]];
            m_udp_length      <= length_mem[rd_ptr[ADDR_W-1:0]];
            m_udp_checksum    <= checksum_mem[rd_ptr[ADDR_W-1:0]];
        end
    end

endmodule

//--- hdl/udp_payload_fifo.sv
// ********************
// DEPTH must be a power of two
// ********************

`timescale 1ns/1ps

module udp_payload_fifo #(
    parameter int DEPTH = 2048
) (
    input  logic                    clk,
    input  logic                    rst,
    udp_byte_if.consumer            pay,
    output udp_checksum_pkg::byte_t m_payload_tdata,
    output logic                    m_payload_tvalid,
    output logic                    m_payload_tlast,
    input  logic                    m_payload_tready
);
    import udp_checksum_pkg::*;

    localparam int ADDR_W = $clog2(DEPTH);

    // byte with its last flag in bit 8
    logic [8:0]      mem [DEPTH];
    logic [ADDR_W:0] wr_ptr;
    logic [ADDR_W:0] rd_ptr;
    logic            full;
    logic            empty;
    logic            wr_en;
    logic            rd_en;

    assign full  = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]) &&
                   (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);
    assign empty = (wr_ptr == rd_ptr);

    assign pay.ready = !full;
    assign wr_en     = pay.valid && pay.ready;
    assign rd_en     = !empty && (m_payload_tready || !m_payload_tvalid);

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr           <= '0;
            rd_ptr           <= '0;
            m_payload_tvalid <= 1'b0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr           <= rd_ptr + 1'b1;
                m_payload_tvalid <= 1'b1;
            end else if (m_payload_tready) begin
                m_payload_tvalid <= 1'b0;
            end
        end

        if (wr_en) begin
            mem[wr_ptr[ADDR_W-1:0]] <= {pay.last, pay.data};
        end
        if (rd_en) begin
            {m_payload_tlast, m_payload_tdata} <= mem[rd_ptr[ADDR_W-1:0]];
        end
    end

endmodule

//--- hdl/udp_checksum_top.sv
// ********************
// UDP length and checksum insertion, one frame summed at a time
// payload may leave ahead of its header record
// ********************

`timescale 1ns/1ps

module udp_checksum_top (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        s_hdr_valid,
    output logic                        s_hdr_ready,
    input  udp_checksum_pkg::ip_addr_t  s_ip_source_ip,
    input  udp_checksum_pkg::ip_addr_t  s_ip_dest_ip,
    input  udp_checksum_pkg::udp_port_t s_udp_source_port,
    input  udp_checksum_pkg::udp_port_t s_udp_dest_port,
    input  udp_checksum_pkg::byte_t     s_payload_tdata,
    input  logic                        s_payload_tvalid,
    input  logic                        s_payload_tlast,
    output logic                        s_payload_tready,
    output logic                        m_hdr_valid,
    input  logic                        m_hdr_ready,
    output udp_checksum_pkg::ip_addr_t  m_ip_source_ip,
    output udp_checksum_pkg::ip_addr_t  m_ip_dest_ip,
    output udp_checksum_pkg::udp_port_t m_udp_source_port,
    output udp_checksum_pkg::udp_port_t m_udp_dest_port,
    output udp_checksum_pkg::udp_len_t  m_udp_length,
    output udp_checksum_pkg::csum_t     m_udp_checksum,
    output udp_checksum_pkg::byte_t     m_payload_tdata,
    output logic                        m_payload_tvalid,
    output logic                        m_payload_tlast,
    input  logic                        m_payload_tready,
    output logic                        busy
);
    import udp_checksum_pkg::*;

    udp_hdr_if  hdr_bus ();
    udp_byte_if pay_bus ();

    udp_sum_engine i_engine (
        .clk               (clk),
        .rst               (rst),
        .s_hdr_valid       (s_hdr_valid),
        .s_hdr_ready       (s_hdr_ready),
        .s_ip_source_ip    (s_ip_source_ip),
        .s_ip_dest_ip      (s_ip_dest_ip),
        .s_udp_source_port (s_udp_source_port),
        .s_udp_dest_port   (s_udp_dest_port),
        .s_payload_tdata   (s_payload_tdata),
        .s_payload_tvalid  (s_payload_tvalid),
        .s_payload_tlast   (s_payload_tlast),
        .s_payload_tready  (s_payload_tready),
        .hdr               (hdr_bus.producer),
        .pay               (pay_bus.producer),
        .busy              (busy)
    );

    udp_header_fifo #(
        .DEPTH (HDR_FIFO_DEPTH)
    ) i_hdr_fifo (
        .clk               (clk),
        .rst               (rst),
        .hdr               (hdr_bus.consumer),
        .m_hdr_valid       (m_hdr_valid),
        .m_hdr_ready       (m_hdr_ready),
        .m_ip_source_ip    (m_ip_source_ip),
        .m_ip_dest_ip      (m_ip_dest_ip),
        .m_udp_source_port (m_udp_source_port),
        .m_udp_dest_port   (m_udp_dest_port),
        .m_udp_length      (m_udp_length),
        .m_udp_checksum    (m_udp_checksum)
    );

    udp_payload_fifo #(
        .DEPTH (PAYLOAD_FIFO_DEPTH)
    ) i_pay_fifo (
        .clk              (clk),
        .rst              (rst),
        .pay              (pay_bus.consumer),
        .m_payload_tdata  (m_payload_tdata),
        .m_payload_tvalid (m_payload_tvalid),
        .m_payload_tlast  (m_payload_tlast),
        .m_payload_tready (m_payload_tready)
    );

endmodule

//--- dv/udp_checksum_properties.sv
// ********************
// handshake rules on the top level ports of udp_checksum_top
// ********************

`timescale 1ns/1ps

module udp_checksum_properties (
    input logic                        clk,
    input logic                        rst,
    input logic                        m_hdr_valid,
    input logic                        m_hdr_ready,
    input udp_checksum_pkg::ip_addr_t  m_ip_source_ip,
    input udp_checksum_pkg::ip_addr_t  m_ip_dest_ip,
    input udp_checksum_pkg::udp_port_t m_udp_source_port,
    input udp_checksum_pkg::udp_port_t m_udp_dest_port,
    input udp_checksum_pkg::udp_len_t  m_udp_length,
    input udp_checksum_pkg::csum_t     m_udp_checksum,
    input udp_checksum_pkg::byte_t     m_payload_tdata,
    input logic                        m_payload_tvalid,
    input logic                        m_payload_tlast,
    input logic                        m_payload_tready,
    input logic                        s_payload_tready,
    input logic                        busy
);

    // a stalled header record keeps every field
    hdr_held: assert property (@(posedge clk) disable iff (rst)
        m_hdr_valid && !m_hdr_ready |=> m_hdr_valid && $stable({m_ip_source_ip,
            m_ip_dest_ip, m_udp_source_port, m_udp_dest_port, m_udp_length, m_udp_checksum}))
        else $error("header output changed while m_hdr_ready was low");

    payload_held: assert property (@(posedge clk) disable iff (rst)
        m_payload_tvalid && !m_payload_tready |=>
            m_payload_tvalid && $stable({m_payload_tlast, m_payload_tdata}))
        else $error("payload output changed while m_payload_tready was low");

    ready_needs_busy: assert property (@(posedge clk) disable iff (rst)
        s_payload_tready |-> busy)
        else $error("s_payload_tready high while busy was low");

endmodule

bind udp_checksum_top udp_checksum_properties i_props (.*);

//--- dv/tb_udp_checksum.sv
// ********************
// 40 random frames checked against a checksum model with random output ready after frame 0
// ********************

`timescale 1ns/1ps

module tb_udp_checksum;
    import udp_checksum_pkg::*;

    localparam int NUM_FRAMES      = 40;
    localparam int MAX_PAYLOAD     = 64;
    localparam int NUM_TESTS       = NUM_FRAMES + 2;
    localparam int DRAIN_ID        = NUM_FRAMES + 1;
    localparam int WATCHDOG_CYCLES = NUM_FRAMES * (MAX_PAYLOAD + 30) * 4;
    localparam int PATTERN_LEN     = 4096;
    localparam logic [31:0] RAND_SEED = 32'h26e0_9519;

    logic      clk;
    logic      rst;
    logic      s_hdr_valid;
    logic      s_hdr_ready;
    ip_addr_t  s_ip_source_ip;
    ip_addr_t  s_ip_dest_ip;
    udp_port_t s_udp_source_port;
    udp_port_t s_udp_dest_port;
    byte_t     s_payload_tdata;
    logic      s_payload_tvalid;
    logic      s_payload_tlast;
    logic      s_payload_tready;
    logic      m_hdr_valid;
    logic      m_hdr_ready;
    ip_addr_t  m_ip_source_ip;
    ip_addr_t  m_ip_dest_ip;
    udp_port_t m_udp_source_port;
    udp_port_t m_udp_dest_port;
    udp_len_t  m_udp_length;
    csum_t     m_udp_checksum;
    byte_t     m_payload_tdata;
    logic      m_payload_tvalid;
    logic      m_payload_tlast;
    logic      m_payload_tready;
    logic      busy;

    // {src_ip, dst_ip, src_port, dst_port} per frame
    logic [95:0]  hdr_in [NUM_FRAMES];
    int           frame_len [NUM_FRAMES];
    int           frame_start [NUM_FRAMES];
    byte_t        pay_bytes [NUM_FRAMES * MAX_PAYLOAD];
    bit           pay_gap [NUM_FRAMES * MAX_PAYLOAD];
    logic [1:0]   ready_pattern [PATTERN_LEN];
    logic [127:0] exp_hdr_q [$];
    logic [8:0]   exp_byte_q [$];
    int           test_errs [NUM_TESTS] = '{default: 0};
    bit           hdr_done [NUM_FRAMES] = '{default: 1'b0};
    bit           pay_done [NUM_FRAMES] = '{default: 1'b0};
    int           error_count = 0;
    int           hdr_count = 0;
    int           byte_count = 0;
    int           pay_frame = 0;
    int           total_bytes = 0;

    udp_checksum_top i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic check_value(input int test_id, input string name,
                               input logic [31:0] expected, input logic [31:0] actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s: expected %0h, actual %0h", name, expected, actual);
            test_errs[test_id]++;
            error_count++;
        end
    endtask

    task automatic report_test(input int test_id, input string name);
        if (test_errs[test_id] == 0) begin
            $display("test %s: pass", name);
        end else begin
            $display("test %s: failed with %0d errors", name, test_errs[test_id]);
        end
    endtask

    // one's complement sum of pseudo header, UDP header and padded payload
    function automatic csum_t model_checksum(input int f);
        logic [31:0] sum;
        logic [15:0] len;
        byte_t       low;
        int          i;
        len = 16'(UDP_HDR_BYTES + frame_len[f]);
        sum = 32'(hdr_in[f][95:80]) + hdr_in[f][79:64] + hdr_in[f][63:48] + hdr_in[f][47:32]
            + 32'(UDP_PROTOCOL) + len + hdr_in[f][31:16] + hdr_in[f][15:0] + len;
        for (i = 0; i < frame_len[f]; i += 2) begin
            low = (i + 1 < frame_len[f]) ? pay_bytes[frame_start[f] + i + 1] : 8'h00;
            sum = sum + {16'd0, pay_bytes[frame_start[f] + i], low};
        end
        while (sum[31:16] != 16'd0) begin
            sum = {16'd0, sum[15:0]} + {16'd0, sum[31:16]};
        end
        return ~sum[15:0];
    endfunction

    task automatic send_frame(input int f);
        int i;
        int idx;
        {s_ip_source_ip, s_ip_dest_ip, s_udp_source_port, s_udp_dest_port} = hdr_in[f];
        s_hdr_valid = 1'b1;
        while (!s_hdr_ready) @(negedge clk);
        @(negedge clk);
        s_hdr_valid = 1'b0;
        for (i = 0; i < frame_len[f]; i++) begin
            idx = frame_start[f] + i;
            if (pay_gap[idx]) @(negedge clk);
            s_payload_tdata  = pay_bytes[idx];
            s_payload_tlast  = (i == frame_len[f] - 1);
            s_payload_tvalid = 1'b1;
            while (!s_payload_tready) @(negedge clk);
            @(negedge clk);
            s_payload_tvalid = 1'b0;
            s_payload_tlast  = 1'b0;
        end
    endtask

    task automatic frame_finished(input int f);
        if (hdr_done[f] && pay_done[f]) begin
            report_test(f + 1, $sformatf("frame %0d (%0d bytes)", f, frame_len[f]));
        end
    endtask

    task automatic take_header();
        logic [127:0] exp;
        string        name;
        if (exp_hdr_q.size() == 0) begin
            $display("ERROR: header record received with no frame left to expect");
            test_errs[DRAIN_ID]++;
            error_count++;
        end else begin
            exp  = exp_hdr_q.pop_front();
            name = $sformatf("frame %0d", hdr_count);
            check_value(hdr_count + 1, {name, " src_ip"}, exp[127:96], m_ip_source_ip);
            check_value(hdr_count + 1, {name, " dst_ip"}, exp[95:64], m_ip_dest_ip);
            check_value(hdr_count + 1, {name, " src_port"}, exp[63:48], m_udp_source_port);
            check_value(hdr_count + 1, {name, " dst_port"}, exp[47:32], m_udp_dest_port);
            check_value(hdr_count + 1, {name, " length"}, exp[31:16], m_udp_length);
            check_value(hdr_count + 1, {name, " checksum"}, exp[15:0], m_udp_checksum);
            hdr_done[hdr_count] = 1'b1;
            frame_finished(hdr_count);
            hdr_count++;
        end
    endtask

    task automatic take_byte();
        logic [8:0] exp;
        string      name;
        if (exp_byte_q.size() == 0) begin
            $display("ERROR: payload byte received with no byte left to expect");
            test_errs[DRAIN_ID]++;
            error_count++;
        end else begin
            exp  = exp_byte_q.pop_front();
            name = $sformatf("frame %0d byte %0d", pay_frame, byte_count);
            check_value(pay_frame + 1, {name, " data"}, exp[7:0], m_payload_tdata);
            check_value(pay_frame + 1, {name, " tlast"}, exp[8], m_payload_tlast);
            byte_count++;
            if (exp[8]) begin
                pay_done[pay_frame] = 1'b1;
                frame_finished(pay_frame);
                pay_frame++;
            end
        end
    endtask

    // drives output ready and records each transfer before its rising edge
    initial begin : output_monitor
        int cyc;
        cyc              = 0;
        m_hdr_ready      = 1'b1;
        m_payload_tready = 1'b1;
        forever begin
            @(negedge clk);
            if (hdr_count == 0) begin
                m_hdr_ready      = 1'b1;
                m_payload_tready = 1'b1;
            end else begin
                {m_hdr_ready, m_payload_tready} = ready_pattern[cyc % PATTERN_LEN];
            end
            cyc++;
            if (!rst && m_hdr_valid && m_hdr_ready) take_header();
            if (!rst && m_payload_tvalid && m_payload_tready) take_byte();
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("ERROR: run timed out after %0d cycles with %0d of %0d headers received",
                 WATCHDOG_CYCLES, hdr_count, NUM_FRAMES);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin : main_flow
        int f;
        int i;
        int len;
        int passed;
        void'($urandom(RAND_SEED));
        rst               = 1'b1;
        s_hdr_valid       = 1'b0;
        s_ip_source_ip    = '0;
        s_ip_dest_ip      = '0;
        s_udp_source_port = '0;
        s_udp_dest_port   = '0;
        s_payload_tdata   = '0;
        s_payload_tvalid  = 1'b0;
        s_payload_tlast   = 1'b0;

        // all random draws up front in one fixed order
        for (i = 0; i < PATTERN_LEN; i++) begin
            ready_pattern[i] = {($urandom % 4) != 0, ($urandom % 4) != 0};
        end
        for (f = 0; f < NUM_FRAMES; f++) begin
            hdr_in[f]      = {$urandom, $urandom, 16'($urandom), 16'($urandom)};
            len            = 1 + ($urandom % MAX_PAYLOAD);
            frame_len[f]   = len;
            frame_start[f] = total_bytes;
            for (i = 0; i < len; i++) begin
                pay_bytes[total_bytes + i] = 8'($urandom);
                pay_gap[total_bytes + i]   = ($urandom % 4) == 0;
                exp_byte_q.push_back({i == len - 1, pay_bytes[total_bytes + i]});
            end
            exp_hdr_q.push_back({hdr_in[f], 16'(UDP_HDR_BYTES + len), model_checksum(f)});
            total_bytes += len;
        end

        repeat (8) @(negedge clk);
        check_value(0, "reset s_hdr_ready", 0, s_hdr_ready);
        check_value(0, "reset s_payload_tready", 0, s_payload_tready);
        check_value(0, "reset m_hdr_valid", 0, m_hdr_valid);
        check_value(0, "reset m_payload_tvalid", 0, m_payload_tvalid);
        check_value(0, "reset busy", 0, busy);
        report_test(0, "reset");
        rst = 1'b0;

        for (f = 0; f < NUM_FRAMES; f++) begin
            send_frame(f);
        end
        wait (hdr_count == NUM_FRAMES && byte_count == total_bytes);
        repeat (2) @(negedge clk);
        check_value(DRAIN_ID, "drain busy", 0, busy);
        check_value(DRAIN_ID, "drain m_hdr_valid", 0, m_hdr_valid);
        check_value(DRAIN_ID, "drain m_payload_tvalid", 0, m_payload_tvalid);
        check_value(DRAIN_ID, "drain s_payload_tready", 0, s_payload_tready);
        report_test(DRAIN_ID, "drain");

        passed = 0;
        for (i = 0; i < NUM_TESTS; i++) begin
            if (test_errs[i] == 0) passed++;
        end
        $display("summary: %0d of %0d tests passed, %0d errors", passed, NUM_TESTS, error_count);
        if (error_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- list.f
hdl/udp_checksum_pkg.sv
hdl/udp_hdr_if.sv
hdl/udp_byte_if.sv
hdl/udp_sum_engine.sv
hdl/udp_header_fifo.sv
hdl/udp_payload_fifo.sv
hdl/udp_checksum_top.sv
dv/udp_checksum_properties.sv
dv/tb_udp_checksum.sv
